// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_cpu
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
FAIL_MSG   := Test failures found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/cpu.sv
module cpu (
    input  logic                 clk,
    input  logic                 arst_n,
    output lc3b_types::lc3b_word imem_addr,
    input  lc3b_types::lc3b_word imem_rdata,
    output lc3b_types::lc3b_word dmem_addr,
    output lc3b_types::lc3b_word dmem_wdata,
    output logic                 dmem_we,
    output logic                 dmem_re,
    input  lc3b_types::lc3b_word dmem_rdata
);
    import lc3b_types::*;

    // hazard controls
    logic stall;
    logic flush_if_id;
    logic flush_id_ex;
    logic flush_ex_mem;
    logic stage_mem_br_en;

    lc3b_word         stage_if_ir;
    lc3b_word         stage_if_pc_plus2;
    lc3b_control_word stage_id_control;
    lc3b_word         stage_id_sr1_val;
    lc3b_word         stage_id_sr2_val;
    lc3b_reg          stage_id_sr1;
    lc3b_reg          stage_id_sr2;
    lc3b_word         stage_ex_alu;
    lc3b_word         stage_ex_pcn;
    lc3b_word         stage_ex_store_data;
    lc3b_word         stage_mem_mdr;

    logic    barrier_if_id_valid;
    logic    barrier_id_ex_valid;
    logic    barrier_ex_mem_valid;
    logic    barrier_mem_wb_valid;
    if_id_t  barrier_if_id_data;
    id_ex_t  barrier_id_ex_data;
    ex_mem_t barrier_ex_mem_data;
    mem_wb_t barrier_mem_wb_data;

    fetch_stage i_fetch_stage (
        .clk,
        .arst_n,
        .hold(stall),
        .redirect(stage_mem_br_en),
        .redirect_pc(barrier_ex_mem_data.pcn),
        .imem_rdata,
        .imem_addr,
        .ir(stage_if_ir),
        .pc_plus2(stage_if_pc_plus2)
    );

    pipe_barrier #(.payload_t(if_id_t)) i_barrier_if_id (
        .clk,
        .arst_n,
        .hold(stall),
        .flush(flush_if_id),
        .in_valid(1'b1),
        .in_data('{ir: stage_if_ir, pc_plus2: stage_if_pc_plus2}),
        .out_valid(barrier_if_id_valid),
        .out_data(barrier_if_id_data)
    );

    decode_stage i_decode_stage (
        .clk,
        .arst_n,
        .ir(barrier_if_id_data.ir),
        .wb_valid(barrier_mem_wb_valid),
        .wb_data(barrier_mem_wb_data),
        .control(stage_id_control),
        .sr1_val(stage_id_sr1_val),
        .sr2_val(stage_id_sr2_val),
        .sr1(stage_id_sr1),
        .sr2(stage_id_sr2)
    );

    pipe_barrier #(.payload_t(id_ex_t)) i_barrier_id_ex (
        .clk,
        .arst_n,
        .hold(1'b0),
        .flush(flush_id_ex),
        .in_valid(barrier_if_id_valid),
        .in_data('{control: stage_id_control, ir: barrier_if_id_data.ir,
                   pc_plus2: barrier_if_id_data.pc_plus2, sr1_val: stage_id_sr1_val,
                   sr2_val: stage_id_sr2_val, sr1: stage_id_sr1, sr2: stage_id_sr2}),
        .out_valid(barrier_id_ex_valid),
        .out_data(barrier_id_ex_data)
    );

    execute_stage i_execute_stage (
        .ex_in(barrier_id_ex_data),
        .ex_mem_valid(barrier_ex_mem_valid),
        .ex_mem_in(barrier_ex_mem_data),
        .wb_valid(barrier_mem_wb_valid),
        .wb_in(barrier_mem_wb_data),
        .alu_result(stage_ex_alu),
        .pcn(stage_ex_pcn),
        .store_data(stage_ex_store_data)
    );

    pipe_barrier #(.payload_t(ex_mem_t)) i_barrier_ex_mem (
        .clk,
        .arst_n,
        .hold(1'b0),
        .flush(flush_ex_mem),
        .in_valid(barrier_id_ex_valid),
        .in_data('{control: barrier_id_ex_data.control, ir: barrier_id_ex_data.ir,
                   alu: stage_ex_alu, pcn: stage_ex_pcn, store_data: stage_ex_store_data}),
        .out_valid(barrier_ex_mem_valid),
        .out_data(barrier_ex_mem_data)
    );

    memory_stage i_memory_stage (
        .clk,
        .arst_n,
        .mem_valid(barrier_ex_mem_valid),
        .mem_in(barrier_ex_mem_data),
        .dmem_rdata,
        .dmem_addr,
        .dmem_wdata,
        .dmem_we,
        .dmem_re,
        .mdr(stage_mem_mdr),
        .br_en(stage_mem_br_en)
    );

    // last barrier is never stalled or flushed
    pipe_barrier #(.payload_t(mem_wb_t)) i_barrier_mem_wb (
        .clk,
        .arst_n,
        .hold(1'b0),
        .flush(1'b0),
        .in_valid(barrier_ex_mem_valid),
        .in_data('{control: barrier_ex_mem_data.control, dest: barrier_ex_mem_data.ir[11:9],
                   alu: barrier_ex_mem_data.alu, mdr: stage_mem_mdr}),
        .out_valid(barrier_mem_wb_valid),
        .out_data(barrier_mem_wb_data)
    );

    hazard_unit i_hazard_unit (
        .id_ex_valid(barrier_id_ex_valid),
        .id_ex_mem_read(barrier_id_ex_data.control.mem_read),
        .id_ex_dest(barrier_id_ex_data.ir[11:9]),
        .if_id_valid(barrier_if_id_valid),
        .if_id_ir(barrier_if_id_data.ir),
        .br_en(stage_mem_br_en),
        .stall,
        .flush_if_id,
        .flush_id_ex,
        .flush_ex_mem
    );

endmodule

// File: rtl/decode_stage.sv
`include "lc3b_macros.svh"

module decode_stage (
    input  logic                         clk,
    input  logic                         arst_n,
    input  lc3b_types::lc3b_word         ir,
    input  logic                         wb_valid,
    input  lc3b_types::mem_wb_t          wb_data,
    output lc3b_types::lc3b_control_word control,
    output lc3b_types::lc3b_word         sr1_val,
    output lc3b_types::lc3b_word         sr2_val,
    output lc3b_types::lc3b_reg          sr1,
    output lc3b_types::lc3b_reg          sr2
);
    import lc3b_types::*;

    lc3b_word regs [`LC3B_REG_COUNT];
    lc3b_word wb_value;
    lc3b_reg  wb_dest;
    logic     wb_en;

    // control decode, unsupported opcodes fall through as no-ops
    always_comb begin
        control        = '0;
        control.opcode = lc3b_opcode'(ir[15:12]);
        control.alu_op = alu_pass_b;
        case (control.opcode)
            add: begin
                control.alu_op    = alu_add;
                control.use_imm   = ir[5];
                control.reg_write = 1'b1;
            end
            and_op: begin
                control.alu_op    = alu_and;
                control.use_imm   = ir[5];
                control.reg_write = 1'b1;
            end
            not_op: begin
                control.alu_op    = alu_not;
                control.reg_write = 1'b1;
            end
            ldr: begin
                control.reg_write = 1'b1;
                control.mem_read  = 1'b1;
            end
            str: begin
                control.mem_write = 1'b1;
            end
            br: begin
                control.is_branch = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // writeback select
    assign wb_dest  = wb_data.dest;
    assign wb_en    = wb_valid && wb_data.control.reg_write;
    assign wb_value = wb_data.control.mem_read ? wb_data.mdr : wb_data.alu;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LC3B_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_dest] <= wb_value;
        end
    end

    // STR reads its source register through the second port
    assign sr1 = ir[8:6];
    assign sr2 = (control.opcode == str) ? ir[11:9] : ir[2:0];

    // same-cycle write goes straight to the read ports
    assign sr1_val = (wb_en && wb_dest == sr1) ? wb_value : regs[sr1];
    assign sr2_val = (wb_en && wb_dest == sr2) ? wb_value : regs[sr2];

endmodule

// File: rtl/execute_stage.sv
module execute_stage (
    input  lc3b_types::id_ex_t   ex_in,
    input  logic                 ex_mem_valid,
    input  lc3b_types::ex_mem_t  ex_mem_in,
    input  logic                 wb_valid,
    input  lc3b_types::mem_wb_t  wb_in,
    output lc3b_types::lc3b_word alu_result,
    output lc3b_types::lc3b_word pcn,
    output lc3b_types::lc3b_word store_data
);
    import lc3b_types::*;

    lc3b_reg  ex_dest;
    logic     ex_fwd;
    logic     wb_fwd;
    lc3b_word wb_value;
    lc3b_word opnd_a;
    lc3b_word opnd_b;
    lc3b_word alu_b;
    lc3b_word imm5;
    lc3b_word offset6;
    lc3b_word pcoffset9;

    // a load never sits in EX/MEM ahead of its user, the stall sees to that
    assign ex_dest = ex_mem_in.ir[11:9];
    assign ex_fwd  = ex_mem_valid && ex_mem_in.control.reg_write;

    assign wb_fwd   = wb_valid && wb_in.control.reg_write;
    assign wb_value = wb_in.control.mem_read ? wb_in.mdr : wb_in.alu;

    // youngest producer first
    always_comb begin
        if (ex_fwd && ex_dest == ex_in.sr1) begin
            opnd_a = ex_mem_in.alu;
        end else if (wb_fwd && wb_in.dest == ex_in.sr1) begin
            opnd_a = wb_value;
        end else begin
            opnd_a = ex_in.sr1_val;
        end
    end

    always_comb begin
        if (ex_fwd && ex_dest == ex_in.sr2) begin
            opnd_b = ex_mem_in.alu;
        end else if (wb_fwd && wb_in.dest == ex_in.sr2) begin
            opnd_b = wb_value;
        end else begin
            opnd_b = ex_in.sr2_val;
        end
    end

    // sign extensions, offsets are word offsets
    assign imm5      = {{11{ex_in.ir[4]}}, ex_in.ir[4:0]};
    assign offset6   = {{9{ex_in.ir[5]}}, ex_in.ir[5:0], 1'b0};
    assign pcoffset9 = {{6{ex_in.ir[8]}}, ex_in.ir[8:0], 1'b0};

    assign alu_b = ex_in.control.use_imm ? imm5 : opnd_b;

    always_comb begin
        case (ex_in.control.alu_op)
            alu_add: alu_result = opnd_a + alu_b;
            alu_and: alu_result = opnd_a & alu_b;
            alu_not: alu_result = ~opnd_a;
            default: alu_result = alu_b;
        endcase
    end

    // shared adder for branch target and LDR/STR address
    assign pcn = ex_in.control.is_branch ? ex_in.pc_plus2 + pcoffset9 : opnd_a + offset6;

    assign store_data = opnd_b;

endmodule

// File: rtl/fetch_stage.sv
`include "lc3b_macros.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 hold,
    input  logic                 redirect,
    input  lc3b_types::lc3b_word redirect_pc,
    input  lc3b_types::lc3b_word imem_rdata,
    output lc3b_types::lc3b_word imem_addr,
    output lc3b_types::lc3b_word ir,
    output lc3b_types::lc3b_word pc_plus2
);
    import lc3b_types::*;

    lc3b_word pc;
    lc3b_word pc_next;

    assign pc_plus2 = pc + `LC3B_PC_STEP;

    // a taken branch overrides a load-use hold
    always_comb begin
        pc_next = pc_plus2;
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (hold) begin
            pc_next = pc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `LC3B_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // instruction memory answers in the same cycle
    assign imem_addr = pc;
    assign ir        = imem_rdata;

endmodule

// File: rtl/hazard_unit.sv
module hazard_unit (
    input  logic                 id_ex_valid,
    input  logic                 id_ex_mem_read,
    input  lc3b_types::lc3b_reg  id_ex_dest,
    input  logic                 if_id_valid,
    input  lc3b_types::lc3b_word if_id_ir,
    input  logic                 br_en,
    output logic                 stall,
    output logic                 flush_if_id,
    output logic                 flush_id_ex,
    output logic                 flush_ex_mem
);
    import lc3b_types::*;

    lc3b_opcode op;
    lc3b_reg    src1;
    lc3b_reg    src2;
    logic       uses_src1;
    logic       uses_src2;
    logic       load_use;

    // source registers the decode stage will read
    assign op   = lc3b_opcode'(if_id_ir[15:12]);
    assign src1 = if_id_ir[8:6];
    assign src2 = (op == str) ? if_id_ir[11:9] : if_id_ir[2:0];

    assign uses_src1 = op inside {add, and_op, not_op, ldr, str};
    assign uses_src2 = ((op == add || op == and_op) && !if_id_ir[5]) || op == str;

    assign load_use = id_ex_valid && id_ex_mem_read && if_id_valid &&
                      ((uses_src1 && src1 == id_ex_dest) || (uses_src2 && src2 == id_ex_dest));

    // a taken branch discards the pair anyway, so it wins over the stall
    assign stall = load_use && !br_en;

    assign flush_if_id  = br_en;
    assign flush_id_ex  = br_en || load_use;
    assign flush_ex_mem = br_en;

    // a valid decode slot never carries an unknown instruction word
    always_comb begin
        assert final (!(if_id_valid === 1'b1 && $isunknown(if_id_ir)))
            else $error("valid IF/ID slot holds an unknown instruction word");
    end

endmodule

// File: rtl/lc3b_macros.svh
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// first fetch address after reset
`define LC3B_RESET_PC 16'h0000

// byte step between instructions, one 16-bit word
`define LC3B_PC_STEP 16'd2

// architectural register count, R0 to R7
`define LC3B_REG_COUNT 8

`endif

// File: rtl/lc3b_types.sv
`include "lc3b_macros.svh"

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [$clog2(`LC3B_REG_COUNT)-1:0] lc3b_reg;

    // ir[15:12] encodings of the full LC-3b set
    typedef enum logic [3:0] {
        br     = 4'b0000, add    = 4'b0001, ldb    = 4'b0010, stb    = 4'b0011,
        jsr    = 4'b0100, and_op = 4'b0101, ldr    = 4'b0110, str    = 4'b0111,
        rti    = 4'b1000, not_op = 4'b1001, ldi    = 4'b1010, sti    = 4'b1011,
        jmp    = 4'b1100, shf    = 4'b1101, lea    = 4'b1110, trap   = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass_b
    } lc3b_alu_op;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_alu_op alu_op;
        logic       use_imm;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       is_branch;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_word ir;
        lc3b_word pc_plus2;
    } if_id_t;

    typedef struct packed {
        lc3b_control_word control;
        lc3b_word         ir;
        lc3b_word         pc_plus2;
        lc3b_word         sr1_val;
        lc3b_word         sr2_val;
        lc3b_reg          sr1;
        lc3b_reg          sr2;
    } id_ex_t;

    // pcn carries the branch target or the LDR/STR address
    typedef struct packed {
        lc3b_control_word control;
        lc3b_word         ir;
        lc3b_word         alu;
        lc3b_word         pcn;
        lc3b_word         store_data;
    } ex_mem_t;

    typedef struct packed {
        lc3b_control_word control;
        lc3b_reg          dest;
        lc3b_word         alu;
        lc3b_word         mdr;
    } mem_wb_t;

endpackage

// File: rtl/memory_stage.sv
module memory_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 mem_valid,
    input  lc3b_types::ex_mem_t  mem_in,
    input  lc3b_types::lc3b_word dmem_rdata,
    output lc3b_types::lc3b_word dmem_addr,
    output lc3b_types::lc3b_word dmem_wdata,
    output logic                 dmem_we,
    output logic                 dmem_re,
    output lc3b_types::lc3b_word mdr,
    output logic                 br_en
);
    import lc3b_types::*;

    logic [2:0] nzp;
    logic [2:0] nzp_next;
    lc3b_word   result;

    assign dmem_addr  = mem_in.pcn;
    assign dmem_wdata = mem_in.store_data;
    assign dmem_we    = mem_valid && mem_in.control.mem_write;
    assign dmem_re    = mem_valid && mem_in.control.mem_read;
    assign mdr        = dmem_rdata;

    // condition codes follow the value written back
    assign result   = mem_in.control.mem_read ? dmem_rdata : mem_in.alu;
    assign nzp_next = {result[15], result == '0, !result[15] && result != '0};

    // reset to Z, matching the zeroed register file
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            nzp <= 3'b010;
        end else if (mem_valid && mem_in.control.reg_write) begin
            nzp <= nzp_next;
        end
    end

    assign br_en = mem_valid && mem_in.control.is_branch && |(mem_in.ir[11:9] & nzp);

    assert property (@(posedge clk) disable iff (!arst_n) !(dmem_we && dmem_re));

endmodule

// File: rtl/pipe_barrier.sv
module pipe_barrier #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     hold,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // flush wins over hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    // payload is only meaningful while out_valid is set
    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

    // hazard controls stay known and never hold and drop an empty slot together
    assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown({hold, flush}) && !(hold && flush && !out_valid));

endmodule

// File: verification/tb_cpu.sv
`include "lc3b_macros.svh"

module tb_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 16;
    localparam int num_tests    = 6;
    // program lengths of the six tests, halt padding included
    localparam int total_insns     = 4 + 18 + 15 + 59 + 84 + 22;
    localparam int watchdog_cycles = total_insns * 10 + num_tests * (reset_cycles + 4);

    localparam logic [3:0] op_add = 4'b0001;
    localparam logic [3:0] op_and = 4'b0101;
    localparam logic [3:0] op_ldr = 4'b0110;
    localparam logic [3:0] op_str = 4'b0111;

    logic        clk;
    logic        arst_n;
    logic [15:0] imem_addr;
    logic [15:0] imem_rdata;
    logic [15:0] dmem_addr;
    logic [15:0] dmem_wdata;
    logic [15:0] dmem_rdata;
    logic        dmem_we;
    logic        dmem_re;

    // word-indexed memories, address bit 0 ignored
    logic [15:0] imem [256];
    logic [15:0] dmem [256];
    logic [15:0] ref_mem [256];
    logic [15:0] ref_regs [8];
    logic [15:0] prog [$];
    logic [31:0] expected [$];
    logic [31:0] observed [$];
    logic [31:0] rng_state;
    int          errors;
    int          passed_tests;
    int          failed_tests;
    string       test_name;

    cpu i_cpu (
        .clk,
        .arst_n,
        .imem_addr,
        .imem_rdata,
        .dmem_addr,
        .dmem_wdata,
        .dmem_we,
        .dmem_re,
        .dmem_rdata
    );

    assign imem_rdata = imem[imem_addr[8:1]];
    // data only comes back while the read strobe is up
    assign dmem_rdata = dmem_re ? dmem[dmem_addr[8:1]] : 16'h0000;

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // data memory write port and store log
    always @(posedge clk) begin
        if (arst_n && dmem_we) begin
            dmem[dmem_addr[8:1]] <= dmem_wdata;
            observed.push_back({dmem_addr, dmem_wdata});
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] alu_reg(input logic [3:0] op, input int dr, input int sr1,
                                            input int sr2);
        return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
    endfunction

    function automatic logic [15:0] alu_imm(input logic [3:0] op, input int dr, input int sr1,
                                            input int imm);
        return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
    endfunction

    function automatic logic [15:0] not_reg(input int dr, input int sr);
        return {4'b1001, 3'(dr), 3'(sr), 6'b111111};
    endfunction

    function automatic logic [15:0] mem_op(input logic [3:0] op, input int r, input int base,
                                           input int off);
        return {op, 3'(r), 3'(base), 6'(off)};
    endfunction

    function automatic logic [15:0] branch(input logic [2:0] cond, input int off);
        return {4'b0000, cond, 9'(off)};
    endfunction

    // instruction-level model of the supported subset, collects the expected stores
    task automatic run_reference(input logic [15:0] halt_pc);
        logic [15:0] pc;
        logic [15:0] insn;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] result;
        logic [15:0] addr;
        logic [2:0]  nzp;
        int          steps;
        pc     = `LC3B_RESET_PC;
        nzp    = 3'b010;
        steps  = 0;
        result = '0;
        for (int i = 0; i < 8; i++) begin
            ref_regs[i] = '0;
        end
        expected.delete();
        while (pc != halt_pc && steps < 1000) begin
            insn  = imem[pc[8:1]];
            pc    = pc + 16'd2;
            steps = steps + 1;
            a     = ref_regs[insn[8:6]];
            b     = insn[5] ? {{11{insn[4]}}, insn[4:0]} : ref_regs[insn[2:0]];
            addr  = a + {{9{insn[5]}}, insn[5:0], 1'b0};
            case (insn[15:12])
                4'b0001: result = a + b;
                4'b0101: result = a & b;
                4'b1001: result = ~a;
                4'b0110: result = ref_mem[addr[8:1]];
                4'b0111: begin
                    ref_mem[addr[8:1]] = ref_regs[insn[11:9]];
                    expected.push_back({addr, ref_regs[insn[11:9]]});
                end
                4'b0000: begin
                    if ((insn[11:9] & nzp) != 3'b000) begin
                        pc = pc + {{6{insn[8]}}, insn[8:0], 1'b0};
                    end
                end
                default: begin
                end
            endcase
            if (insn[15:12] inside {4'b0001, 4'b0101, 4'b1001, 4'b0110}) begin
                ref_regs[insn[11:9]] = result;
                nzp = {result[15], result == 16'd0, !result[15] && result != 16'd0};
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #10 arst_n = 1'b0;
        repeat (reset_cycles) begin
            @(negedge clk);
            if (dmem_we !== 1'b0 || dmem_re !== 1'b0) begin
                $display("CHECK FAILED %s reset strobes: expected 00, actual %b%b",
                         test_name, dmem_we, dmem_re);
                errors++;
            end
        end
        @(posedge clk);
        #10 arst_n = 1'b1;
        @(negedge clk);
        if (imem_addr !== `LC3B_RESET_PC) begin
            $display("CHECK FAILED %s first fetch: expected %h, actual %h",
                     test_name, `LC3B_RESET_PC, imem_addr);
            errors++;
        end
        if (dmem_we !== 1'b0 || dmem_re !== 1'b0) begin
            $display("CHECK FAILED %s strobes after reset: expected 00, actual %b%b",
                     test_name, dmem_we, dmem_re);
            errors++;
        end
    endtask

    // done once the halt branch has redirected fetch back onto itself
    task automatic wait_for_halt(input logic [15:0] halt_pc, input int max_cycles,
                                 output bit done);
        int cycles;
        int phase;
        cycles = 0;
        phase  = 0;
        done   = 1'b0;
        while (!done && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
            case (phase)
                0: if (imem_addr == halt_pc) phase = 1;
                1: if (imem_addr != halt_pc) phase = 2;
                default: if (imem_addr == halt_pc) done = 1'b1;
            endcase
        end
    endtask

    task automatic compare_stores();
        if (observed.size() != expected.size()) begin
            $display("CHECK FAILED %s store count: expected %0d, actual %0d",
                     test_name, expected.size(), observed.size());
            errors++;
        end
        for (int i = 0; i < expected.size() && i < observed.size(); i++) begin
            if (observed[i] != expected[i]) begin
                $display("CHECK FAILED %s store %0d: expected %h:%h, actual %h:%h", test_name, i,
                         expected[i][31:16], expected[i][15:0],
                         observed[i][31:16], observed[i][15:0]);
                errors++;
            end
        end
    endtask

    // pads the program, loads memories, resets the DUT and checks the stores
    task automatic run_program(input string name);
        logic [15:0] halt_pc;
        bit          done;
        int          insns;
        test_name = name;
        errors    = 0;
        repeat (3) prog.push_back(16'h0000);
        halt_pc = 16'(prog.size() * 2);
        // branch always to itself
        prog.push_back(16'h0FFF);
        insns = prog.size();
        for (int i = 0; i < 256; i++) begin
            imem[i]    = (i < insns) ? prog[i] : 16'h0000;
            dmem[i]    = 16'(i * 261) ^ 16'ha5c3;
            ref_mem[i] = dmem[i];
        end
        run_reference(halt_pc);
        observed.delete();
        apply_reset();
        wait_for_halt(halt_pc, insns * 10, done);
        if (!done) begin
            $display("%s: the program did not reach its halt loop in time", name);
            errors++;
        end
        compare_stores();
        if (errors == 0) begin
            passed_tests++;
            $display("PASS %s (%0d stores)", name, observed.size());
        end else begin
            failed_tests++;
            $display("FAIL %s (%0d errors)", name, errors);
        end
        prog.delete();
    endtask

    task automatic reset_state();
        run_program("reset_state");
    endtask

    task automatic alu_chain();
        prog.push_back(alu_imm(op_add, 1, 0, 7));
        prog.push_back(alu_imm(op_add, 2, 1, -3));
        prog.push_back(alu_reg(op_and, 3, 2, 1));
        prog.push_back(not_reg(4, 3));
        prog.push_back(alu_reg(op_add, 5, 4, 3));
        prog.push_back(alu_imm(op_and, 6, 5, 13));
        prog.push_back(alu_reg(op_add, 7, 6, 4));
        for (int r = 7; r >= 1; r--) begin
            prog.push_back(mem_op(op_str, r, 0, r));
        end
        run_program("alu_chain");
    endtask

    task automatic load_use();
        prog.push_back(alu_imm(op_add, 1, 0, 9));
        prog.push_back(alu_imm(op_add, 2, 0, -6));
        prog.push_back(mem_op(op_str, 1, 0, 4));
        prog.push_back(mem_op(op_ldr, 3, 0, 4));
        prog.push_back(alu_reg(op_add, 4, 3, 2));
        prog.push_back(mem_op(op_str, 4, 0, 5));
        // dependent store data
        prog.push_back(mem_op(op_ldr, 5, 0, 5));
        prog.push_back(mem_op(op_str, 5, 0, 6));
        // preloaded word
        prog.push_back(mem_op(op_ldr, 6, 0, 20));
        prog.push_back(not_reg(7, 6));
        prog.push_back(mem_op(op_str, 7, 0, 7));
        run_program("load_use");
    endtask

    // flag-setting add, branch over two stores, then the target store
    task automatic branch_block(input int value, input logic [2:0] cond, input int blk);
        prog.push_back(alu_imm(op_add, 1, 0, value));
        prog.push_back(branch(cond, 2));
        for (int k = 0; k < 3; k++) begin
            prog.push_back(mem_op(op_str, 1, 0, blk * 3 + k - 16));
        end
    endtask

    task automatic branch_paths();
        int values [3] = '{-4, 0, 6};
        int blk;
        blk = 0;
        for (int v = 0; v < 3; v++) begin
            for (int c = 0; c < 3; c++) begin
                branch_block(values[v], 3'b100 >> c, blk);
                blk++;
            end
        end
        branch_block(6, 3'b111, blk);
        branch_block(-4, 3'b000, blk + 1);
        run_program("branch_paths");
    endtask

    task automatic random_alu();
        int dr;
        int sr1;
        int sr2;
        int imm;
        for (int i = 0; i < 40; i++) begin
            rng_state = xorshift(rng_state);
            dr  = 1 + int'(rng_state[2:0]) % 7;
            sr1 = int'(rng_state[5:3]);
            sr2 = int'(rng_state[8:6]);
            imm = int'(rng_state[13:9]);
            case (int'(rng_state[17:14]) % 5)
                0: prog.push_back(alu_reg(op_add, dr, sr1, sr2));
                1: prog.push_back(alu_imm(op_add, dr, sr1, imm));
                2: prog.push_back(alu_reg(op_and, dr, sr1, sr2));
                3: prog.push_back(alu_imm(op_and, dr, sr1, imm));
                default: prog.push_back(not_reg(dr, sr1));
            endcase
            prog.push_back(mem_op(op_str, dr, 0, i - 16));
        end
        run_program("random_alu");
    endtask

    task automatic unsupported_ops();
        logic [15:0] others [10] = '{16'h2281, 16'h3281, 16'h4800, 16'h8000, 16'hA3C0,
                                     16'hB281, 16'hC1C0, 16'hD25F, 16'hE3FF, 16'hF025};
        prog.push_back(alu_imm(op_add, 1, 0, 5));
        prog.push_back(alu_imm(op_add, 2, 0, -2));
        for (int i = 0; i < 10; i++) begin
            prog.push_back(others[i]);
        end
        // condition codes must still say negative
        prog.push_back(branch(3'b100, 1));
        prog.push_back(mem_op(op_str, 1, 0, 3));
        prog.push_back(mem_op(op_str, 1, 0, 0));
        prog.push_back(mem_op(op_str, 2, 0, 1));
        prog.push_back(alu_reg(op_add, 3, 1, 2));
        prog.push_back(mem_op(op_str, 3, 0, 2));
        run_program("unsupported_ops");
    endtask

    initial begin
        arst_n       = 1'b0;
        rng_state    = 32'he6e1_6abd;
        errors       = 0;
        passed_tests = 0;
        failed_tests = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 16'h0000;
            dmem[i] = 16'h0000;
        end
        reset_state();
        alu_chain();
        load_use();
        branch_paths();
        random_alu();
        unsupported_ops();
        $display("%0d tests passed, %0d tests failed", passed_tests, failed_tests);
        if (failed_tests == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/lc3b_types.sv
rtl/pipe_barrier.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/hazard_unit.sv
rtl/cpu.sv
verification/tb_cpu.sv
